//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vload
FILELIST  ?= vload.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- beat_gather.sv
`timescale 1ns/1ps

module beat_gather (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 beat_valid,
    input  vload_pkg::beat_idx_t beat_idx,
    input  vload_pkg::mem_rsp_t  mem_rsp,
    output vload_pkg::vreg_t     buffer
);

    vload_pkg::beat_t beat;

    assign beat = vload_pkg::beat_t'(mem_rsp);

    // slots above the beat count keep the zeros from clear
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            buffer <= '0;
        end else if (beat_valid) begin
            for (int j = 0; j < vload_pkg::num_lanes; j++) begin
                buffer[beat_idx * vload_pkg::beat_w + j * vload_pkg::lane_w
                       +: vload_pkg::lane_w] <= beat[j];
            end
        end
    end

endmodule

//--- stride_compact.sv
`timescale 1ns/1ps

module stride_compact (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 compact_go,
    input  vload_pkg::load_cmd_t cmd_q,
    input  logic [2:0]           num_beats,
    input  vload_pkg::vreg_t     buffer,
    output logic                 done,
    output vload_pkg::vreg_t     result
);

    logic [1:0]       ew_log2;
    logic [2:0]       ew_mask;
    logic [6:0]       elem_cnt;
    logic             strided;
    vload_pkg::vreg_t compacted;

    // element width in bytes as a power of two
    always_comb begin
        case (cmd_q.op)
            vload_pkg::vle16, vload_pkg::vlse16: ew_log2 = 2'd1;
            vload_pkg::vle32, vload_pkg::vlse32: ew_log2 = 2'd2;
            default:                             ew_log2 = 2'd0;
        endcase
    end

    assign ew_mask  = (3'd1 << ew_log2) - 3'd1;
    // 16 bytes per beat
    assign elem_cnt = {num_beats, 4'b0000} >> ew_log2;
    assign strided  = cmd_q.op inside {vload_pkg::vlse8, vload_pkg::vlse16, vload_pkg::vlse32};

    // byte b belongs to result element b/ew, taken from element (b/ew)*stride
    always_comb begin
        logic [5:0]  elem;
        logic [1:0]  sub;
        logic [11:0] src_elem;
        logic [13:0] src_byte;
        compacted = '0;
        for (int b = 0; b < vload_pkg::vreg_w / 8; b++) begin
            elem     = 6'(b >> ew_log2);
            sub      = 2'(b) & ew_mask[1:0];
            src_elem = 12'(elem) * 12'(cmd_q.stride);
            src_byte = (14'(src_elem) << ew_log2) | 14'(sub);
            if (src_elem < 12'(elem_cnt)) begin
                compacted[b*8 +: 8] = buffer[src_byte[5:0]*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= compact_go;
            if (compact_go) begin
                // stride 0 or 1 copies the buffer
                result <= (strided && cmd_q.stride >= 6'd2) ? compacted : buffer;
            end
        end
    end

    a_go_valid_op: assert property (@(posedge clk) disable iff (reset)
        compact_go |-> (cmd_q.op >= vload_pkg::vle8 && cmd_q.op <= vload_pkg::vlse32))
        else $error("compaction started for an invalid op");

endmodule

//--- tb_vload.sv
`timescale 1ns/1ps

module tb_vload;

    typedef struct packed {
        vload_pkg::vload_op_e op;
        vload_pkg::lmul_t     lmul;
        vload_pkg::stride_t   stride;
        logic [13:0]          base;
        logic [2:0]           beats;
        vload_pkg::vreg_t     expected;
    } load_entry_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 start;
    vload_pkg::load_cmd_t cmd;
    vload_pkg::mem_rsp_t  mem_rsp;
    logic                 mem_rd_en;
    logic [13:0]          mem_row;
    logic                 done;
    logic                 busy;
    vload_pkg::vreg_t     result;

    load_entry_t loads[$];
    integer      seed;
    int          errors;
    int          checks;
    bit          timed_out;

    always #5 clk = ~clk;

    vload_top #(
        .row_w (14)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cmd       (cmd),
        .mem_rsp   (mem_rsp),
        .mem_rd_en (mem_rd_en),
        .mem_row   (mem_row),
        .done      (done),
        .busy      (busy),
        .result    (result)
    );

    tb_vload_mem #(
        .row_w (14)
    ) mem (
        .clk   (clk),
        .rd_en (mem_rd_en),
        .row   (mem_row),
        .rsp   (mem_rsp)
    );

    task automatic check_value(input string name, input vload_pkg::vreg_t got,
                               input vload_pkg::vreg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %0h expected %0h", name, got, exp);
        end
    endtask

    function automatic vload_pkg::lane_t mem_word(input logic [13:0] row, input int lane);
        logic [31:0] idx;
        idx = {16'd0, row, 2'(lane)};
        return (idx * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [2:0] beats_for(input vload_pkg::lmul_t lmul);
        case (lmul)
            3'd1:    return 3'd2;
            3'd2:    return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

    // gathered rows, then element i taken from element i*stride of the buffer
    function automatic vload_pkg::vreg_t expected_result(input load_entry_t e);
        vload_pkg::vreg_t buffer;
        vload_pkg::vreg_t res;
        logic [13:0]      row;
        int               ew;
        int               elem_cnt;
        int               src;
        buffer = '0;
        for (int k = 0; k < int'(e.beats); k++) begin
            row = e.base + 14'(k);
            for (int j = 0; j < 4; j++) begin
                buffer[k*128 + j*32 +: 32] = mem_word(row, j);
            end
        end
        case (e.op)
            vload_pkg::vle16, vload_pkg::vlse16: ew = 2;
            vload_pkg::vle32, vload_pkg::vlse32: ew = 4;
            default:                             ew = 1;
        endcase
        if (e.op inside {vload_pkg::vle8, vload_pkg::vle16, vload_pkg::vle32}
            || e.stride < 6'd2) begin
            return buffer;
        end
        elem_cnt = int'(e.beats) * 16 / ew;
        res = '0;
        for (int i = 0; i < 64 / ew; i++) begin
            src = i * int'(e.stride);
            if (src < elem_cnt) begin
                for (int s = 0; s < ew; s++) begin
                    res[(i*ew + s)*8 +: 8] = buffer[(src*ew + s)*8 +: 8];
                end
            end
        end
        return res;
    endfunction

    function automatic logic [13:0] next_base();
        logic [31:0] r;
        r = $random(seed);
        return r[13:0];
    endfunction

    task automatic add_entry(input vload_pkg::vload_op_e op, input vload_pkg::lmul_t lmul,
                             input vload_pkg::stride_t stride, input logic [13:0] base);
        load_entry_t e;
        e.op       = op;
        e.lmul     = lmul;
        e.stride   = stride;
        e.base     = base;
        e.beats    = beats_for(lmul);
        e.expected = '0;
        e.expected = expected_result(e);
        loads.push_back(e);
    endtask

    task automatic build_table();
        vload_pkg::stride_t strides[5];
        strides = '{6'd2, 6'd3, 6'd5, 6'd16, 6'd63};
        for (int o = 1; o <= 3; o++) begin
            for (int l = 0; l <= 2; l++) begin
                add_entry(vload_pkg::vload_op_e'(4'(o)), 3'(l), 6'd0, next_base());
            end
        end
        // reserved lmul codes
        add_entry(vload_pkg::vle8, 3'd5, 6'd0, next_base());
        add_entry(vload_pkg::vle32, 3'd7, 6'd0, next_base());
        // unit-stride loads ignore the stride field
        add_entry(vload_pkg::vle8, 3'd1, 6'd3, next_base());
        add_entry(vload_pkg::vle16, 3'd2, 6'd5, next_base());
        add_entry(vload_pkg::vle32, 3'd2, 6'd16, next_base());
        for (int o = 4; o <= 6; o++) begin
            for (int s = 0; s < 5; s++) begin
                add_entry(vload_pkg::vload_op_e'(4'(o)), 3'd2, strides[s], next_base());
            end
            add_entry(vload_pkg::vload_op_e'(4'(o)), 3'd2, 6'd0, next_base());
            add_entry(vload_pkg::vload_op_e'(4'(o)), 3'd2, 6'd1, next_base());
        end
        add_entry(vload_pkg::vlse16, 3'd0, 6'd0, next_base());
        add_entry(vload_pkg::vlse32, 3'd1, 6'd1, next_base());
        add_entry(vload_pkg::vlse8, 3'd0, 6'd3, next_base());
        add_entry(vload_pkg::vlse32, 3'd1, 6'd2, next_base());
        // row address wraps at the top of the memory
        add_entry(vload_pkg::vle32, 3'd2, 6'd0, 14'h3ffe);
        add_entry(vload_pkg::vlse16, 3'd2, 6'd3, 14'h3fff);
    endtask

    task automatic run_load(input load_entry_t e, input int idx);
        vload_pkg::load_cmd_t c;
        logic [13:0]          row;
        int                   k;
        bit                   seen;
        c.op     = e.op;
        c.lmul   = e.lmul;
        c.stride = e.stride;
        c.row    = e.base;
        @(posedge clk);
        start <= 1'b1;
        cmd   <= c;
        // edge 0 samples start
        @(posedge clk);
        start <= 1'b0;
        k = 0;
        seen = 1'b0;
        while (!seen && k < 50) begin
            @(negedge clk);
            row = e.base + 14'(k);
            if (k < int'(e.beats)) begin
                check_value("mem_rd_en", vload_pkg::vreg_t'(mem_rd_en), vload_pkg::vreg_t'(1));
                check_value("mem_row", vload_pkg::vreg_t'(mem_row), vload_pkg::vreg_t'(row));
            end else begin
                check_value("mem_rd_en", vload_pkg::vreg_t'(mem_rd_en), '0);
            end
            // busy from the start edge until the done edge
            check_value("busy", vload_pkg::vreg_t'(busy),
                        vload_pkg::vreg_t'(k < int'(e.beats) + 2));
            if (done) begin
                seen = 1'b1;
                check_value("done_edge", vload_pkg::vreg_t'(k),
                            vload_pkg::vreg_t'(int'(e.beats) + 2));
                check_value("result", result, e.expected);
            end
            k++;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: load entry %0d gave no done strobe within 50 cycles", idx);
        end else begin
            @(negedge clk);
            check_value("done", vload_pkg::vreg_t'(done), '0);
            check_value("busy", vload_pkg::vreg_t'(busy), '0);
        end
    endtask

    // invalid ops must leave the unit idle
    task automatic run_ignored(input logic [3:0] op);
        vload_pkg::load_cmd_t c;
        c.op     = vload_pkg::vload_op_e'(op);
        c.lmul   = 3'd2;
        c.stride = 6'd0;
        c.row    = next_base();
        @(posedge clk);
        start <= 1'b1;
        cmd   <= c;
        @(posedge clk);
        start <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_value("mem_rd_en", vload_pkg::vreg_t'(mem_rd_en), '0);
            check_value("done", vload_pkg::vreg_t'(done), '0);
            check_value("busy", vload_pkg::vreg_t'(busy), '0);
        end
    endtask

    initial begin
        seed      = 32'h7c58_98f5;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        reset <= 1'b1;
        start <= 1'b0;
        cmd   <= '0;
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("done", vload_pkg::vreg_t'(done), '0);
        check_value("busy", vload_pkg::vreg_t'(busy), '0);
        check_value("mem_rd_en", vload_pkg::vreg_t'(mem_rd_en), '0);
        check_value("result", result, '0);
        run_ignored(4'd0);
        run_ignored(4'd7);
        for (int i = 0; i < loads.size() && !timed_out; i++) begin
            run_load(loads[i], i);
        end
        $display("vload test: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_vload_mem.sv
`timescale 1ns/1ps

module tb_vload_mem #(
    parameter int row_w = 14
) (
    input  logic                clk,
    input  logic                rd_en,
    input  logic [row_w-1:0]    row,
    output vload_pkg::mem_rsp_t rsp
);

    // bank j of row r holds a hash of the word index r*4+j
    function automatic vload_pkg::lane_t content(input logic [row_w-1:0] r, input int j);
        logic [31:0] word_idx;
        word_idx = 32'(r) * 32'd4 + 32'(j);
        return (word_idx * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    initial begin
        rsp = '0;
    end

    // one cycle of read latency, same row on all banks
    always @(posedge clk) begin
        if (rd_en) begin
            rsp.lane0 <= content(row, 0);
            rsp.lane1 <= content(row, 1);
            rsp.lane2 <= content(row, 2);
            rsp.lane3 <= content(row, 3);
        end
    end

endmodule

//--- vload.f
vload_pkg.sv
vload_ctrl.sv
beat_gather.sv
stride_compact.sv
vload_top.sv
tb_vload_mem.sv
tb_vload.sv

//--- vload_ctrl.sv
`timescale 1ns/1ps

module vload_ctrl #(
    parameter int row_w = 14
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  vload_pkg::load_cmd_t cmd,
    output logic                 mem_rd_en,
    output logic [row_w-1:0]     mem_row,
    output logic                 busy,
    output logic                 clear,
    output logic                 beat_valid,
    output vload_pkg::beat_idx_t beat_idx,
    output logic                 compact_go,
    output vload_pkg::load_cmd_t cmd_q,
    output logic [2:0]           num_beats
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_drain,
        st_compact
    } state_e;

    state_e               state;
    vload_pkg::beat_idx_t rd_idx;
    logic [2:0]           beats_dec;
    logic                 op_ok;
    logic                 accept;
    logic                 last_rd;

    // reserved lmul codes fall back to a single beat
    always_comb begin
        case (cmd.lmul)
            3'd1:    beats_dec = 3'd2;
            3'd2:    beats_dec = 3'd4;
            default: beats_dec = 3'd1;
        endcase
    end

    assign op_ok   = cmd.op >= vload_pkg::vle8 && cmd.op <= vload_pkg::vlse32;
    assign accept  = state == st_idle && start && op_ok;
    assign last_rd = {1'b0, rd_idx} == num_beats - 3'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            rd_idx     <= '0;
            clear      <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            clear      <= accept;
            // memory answers one cycle after the read
            beat_valid <= mem_rd_en;
            case (state)
                st_idle: begin
                    rd_idx <= '0;
                    if (accept) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (last_rd) begin
                        state <= st_drain;
                    end else begin
                        rd_idx <= rd_idx + 2'd1;
                    end
                end
                st_drain:   state <= st_compact;
                st_compact: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        beat_idx <= rd_idx;
        if (accept) begin
            cmd_q     <= cmd;
            num_beats <= beats_dec;
        end
    end

    // same row on all four banks
    assign mem_row    = row_w'(cmd_q.row) + row_w'(rd_idx);
    assign mem_rd_en  = state == st_fetch;
    assign compact_go = state == st_compact;
    assign busy       = state != st_idle;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy)
        else $error("start raised while a load is in flight");

    a_beat_in_range: assert property (@(posedge clk) disable iff (reset)
        beat_valid |-> {1'b0, beat_idx} < num_beats)
        else $error("returning beat index outside the load");

endmodule

//--- vload_pkg.sv
package vload_pkg;

    localparam int lane_w    = 32;
    localparam int num_lanes = 4;
    localparam int beat_w    = lane_w * num_lanes;
    localparam int max_beats = 4;
    localparam int vreg_w    = beat_w * max_beats;

    typedef logic [lane_w-1:0] lane_t;
    // one row as four bank words, lane 0 in the low bits
    typedef lane_t [num_lanes-1:0] beat_t;
    typedef logic [vreg_w-1:0] vreg_t;

    typedef logic [1:0] beat_idx_t;
    typedef logic [5:0] stride_t;
    typedef logic [2:0] lmul_t;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        vle8    = 4'd1,
        vle16   = 4'd2,
        vle32   = 4'd3,
        vlse8   = 4'd4,
        vlse16  = 4'd5,
        vlse32  = 4'd6
    } vload_op_e;

    // start payload
    typedef struct packed {
        vload_op_e   op;
        lmul_t       lmul;
        stride_t     stride;
        logic [13:0] row;
    } load_cmd_t;

    typedef struct packed {
        lane_t lane3;
        lane_t lane2;
        lane_t lane1;
        lane_t lane0;
    } mem_rsp_t;

endpackage

//--- vload_top.sv
`timescale 1ns/1ps

module vload_top #(
    parameter int row_w = 14
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  vload_pkg::load_cmd_t cmd,
    input  vload_pkg::mem_rsp_t  mem_rsp,
    output logic                 mem_rd_en,
    output logic [row_w-1:0]     mem_row,
    output logic                 done,
    output logic                 busy,
    output vload_pkg::vreg_t     result
);

    logic                 clear;
    logic                 beat_valid;
    vload_pkg::beat_idx_t beat_idx;
    logic                 compact_go;
    vload_pkg::load_cmd_t cmd_q;
    logic [2:0]           num_beats;
    vload_pkg::vreg_t     buffer;

    vload_ctrl #(
        .row_w (row_w)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cmd        (cmd),
        .mem_rd_en  (mem_rd_en),
        .mem_row    (mem_row),
        .busy       (busy),
        .clear      (clear),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .compact_go (compact_go),
        .cmd_q      (cmd_q),
        .num_beats  (num_beats)
    );

    beat_gather u_gather (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .mem_rsp    (mem_rsp),
        .buffer     (buffer)
    );

    stride_compact u_compact (
        .clk        (clk),
        .reset      (reset),
        .compact_go (compact_go),
        .cmd_q      (cmd_q),
        .num_beats  (num_beats),
        .buffer     (buffer),
        .done       (done),
        .result     (result)
    );

endmodule
